/* Makefile */
VERILATOR ?= verilator
TOP       ?= exmem_tb
RTL_TOP   ?= exmem_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Wall +incdir+hw hw/exmem_pkg.sv hw/alu.sv hw/ex_stage.sv \
		hw/mem_stage.sv hw/data_sram.sv hw/exmem_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/alu.sv */
`timescale 1ns/1ps
`include "exmem_config.svh"
`default_nettype none

module alu (
    input  logic               clk,
    input  logic               resetn,
    input  logic               alu_start,
    input  exmem_pkg::alu_op_t alu_op,
    input  exmem_pkg::word_t   alu_src1,
    input  exmem_pkg::word_t   alu_src2,
    output exmem_pkg::word_t   alu_result,
    output logic               complete
);

    exmem_pkg::word_t      add_res, sub_res, slt_res, sltu_res;
    exmem_pkg::word_t      sll_res, srl_res, sra_res;
    logic [63:0]           prod_s, prod_u;
    logic                  div_op, div_signed, div_is_mod, src2_zero, q_neg, r_neg;
    exmem_pkg::word_t      dend_abs, dvs_abs, quo_fix, rem_fix, div_res;
    exmem_pkg::div_state_t div_state;
    logic [5:0]            div_cnt;
    exmem_pkg::word_t      div_quo, div_rem, div_dvs;
    logic [32:0]           div_part;
    logic [33:0]           div_diff;

    assign add_res  = alu_src1 + alu_src2;
    assign sub_res  = alu_src1 - alu_src2;
    assign slt_res  = exmem_pkg::word_t'($signed(alu_src1) < $signed(alu_src2));
    assign sltu_res = exmem_pkg::word_t'(alu_src1 < alu_src2);
    assign sll_res  = alu_src1 << alu_src2[4:0];
    assign srl_res  = alu_src1 >> alu_src2[4:0];
    assign sra_res  = exmem_pkg::word_t'($signed(alu_src1) >>> alu_src2[4:0]);
    assign prod_s   = $signed(alu_src1) * $signed(alu_src2);
    assign prod_u   = alu_src1 * alu_src2;

    assign div_op     = alu_op[`EXMEM_OP_DIV] | alu_op[`EXMEM_OP_DIVU] |
                        alu_op[`EXMEM_OP_MOD] | alu_op[`EXMEM_OP_MODU];
    assign div_signed = alu_op[`EXMEM_OP_DIV] | alu_op[`EXMEM_OP_MOD];
    assign div_is_mod = alu_op[`EXMEM_OP_MOD] | alu_op[`EXMEM_OP_MODU];
    assign src2_zero  = (alu_src2 == '0);
    assign q_neg      = div_signed & (alu_src1[31] ^ alu_src2[31]);
    assign r_neg      = div_signed & alu_src1[31];   // remainder follows dividend
    assign dend_abs   = (div_signed && alu_src1[31]) ? -alu_src1 : alu_src1;
    assign dvs_abs    = (div_signed && alu_src2[31]) ? -alu_src2 : alu_src2;

    // one quotient bit per busy cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_state <= exmem_pkg::DIV_IDLE;
            div_cnt   <= '0;
        end else if (alu_start) begin
            div_state <= div_op ? exmem_pkg::DIV_BUSY : exmem_pkg::DIV_IDLE;
            div_cnt   <= '0;
        end else if (div_state == exmem_pkg::DIV_BUSY) begin
            div_cnt <= div_cnt + 6'd1;
            if (div_cnt == 6'd31) begin
                div_state <= exmem_pkg::DIV_DONE;
            end
        end
    end

    assign div_part = {div_rem, div_quo[31]};              // shift next dividend bit in
    assign div_diff = {1'b0, div_part} - {2'b00, div_dvs};

    always_ff @(posedge clk) begin
        if (alu_start) begin
            div_quo <= dend_abs;
            div_rem <= '0;
            div_dvs <= dvs_abs;
        end else if (div_state == exmem_pkg::DIV_BUSY) begin
            div_quo <= {div_quo[30:0], ~div_diff[33]};
            div_rem <= div_diff[33] ? div_part[31:0] : div_diff[31:0];  // restore on borrow
        end
    end

    assign quo_fix = src2_zero ? '1 : (q_neg ? -div_quo : div_quo);
    assign rem_fix = src2_zero ? alu_src1 : (r_neg ? -div_rem : div_rem);
    assign div_res = div_is_mod ? rem_fix : quo_fix;

    // a fresh start masks a stale done from the previous divide
    assign complete = div_op ? ((div_state == exmem_pkg::DIV_DONE) && !alu_start) : 1'b1;

    assign alu_result = ({`EXMEM_XLEN{alu_op[`EXMEM_OP_ADD]}}   & add_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SUB]}}   & sub_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SLT]}}   & slt_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SLTU]}}  & sltu_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_AND]}}   & (alu_src1 & alu_src2))
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_OR]}}    & (alu_src1 | alu_src2))
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_NOR]}}   & ~(alu_src1 | alu_src2))
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_XOR]}}   & (alu_src1 ^ alu_src2))
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SLL]}}   & sll_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SRL]}}   & srl_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_SRA]}}   & sra_res)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_LUI]}}   & alu_src2)
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_MUL]}}   & prod_u[31:0])
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_MULH]}}  & prod_s[63:32])
                      | ({`EXMEM_XLEN{alu_op[`EXMEM_OP_MULHU]}} & prod_u[63:32])
                      | ({`EXMEM_XLEN{div_op}}                  & div_res);

endmodule

`default_nettype wire

/* hw/data_sram.sv */
`timescale 1ns/1ps
`include "exmem_config.svh"
`default_nettype none

module data_sram (
    input  logic                clk,
    input  logic                en,
    input  exmem_pkg::byte_en_t we,
    input  exmem_pkg::word_t    addr,
    input  exmem_pkg::word_t    wdata,
    output exmem_pkg::word_t    rdata
);

    exmem_pkg::word_t         mem [0:(1 << `EXMEM_SRAM_AW)-1];
    logic [`EXMEM_SRAM_AW-1:0] word_idx;

    assign word_idx = addr[`EXMEM_SRAM_AW+1:2];   // byte address to word index

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[word_idx];   // old contents on a write
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   id_to_ex_valid,
    input  exmem_pkg::id_to_ex_t   id_to_ex_bus,
    input  logic                   mem_allowin,
    input  logic                   ertn_flush,
    output logic                   ex_allowin,
    output exmem_pkg::ex_fwd_t     ex_fwd_bus,
    output logic                   ex_to_mem_valid,
    output exmem_pkg::ex_to_mem_t  ex_to_mem_bus,
    output logic                   sram_en,
    output exmem_pkg::byte_en_t    sram_we,
    output exmem_pkg::word_t       sram_addr,
    output exmem_pkg::word_t       sram_wdata
);

    logic                 ex_valid;
    exmem_pkg::id_to_ex_t ex_inst;
    logic                 alu_start;
    exmem_pkg::word_t     alu_result;
    logic                 alu_complete;
    logic                 ex_ready_go;
    logic                 to_mem_go;
    logic [1:0]           byte_off;
    exmem_pkg::byte_en_t  store_be;

    assign ex_ready_go     = alu_complete;   // divide holds the stage
    assign ex_allowin      = ~ex_valid | (ex_ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ex_ready_go & ~ertn_flush;
    assign to_mem_go       = ex_to_mem_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ertn_flush) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_inst <= id_to_ex_bus;
        end
    end

    // one pulse in the first valid cycle of each new instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            alu_start <= 1'b0;
        end else begin
            alu_start <= id_to_ex_valid & ex_allowin & ~ertn_flush;
        end
    end

    alu u_alu (
        .clk        (clk),
        .resetn     (resetn),
        .alu_start  (alu_start),
        .alu_op     (ex_inst.alu_op),
        .alu_src1   (ex_inst.alu_src1),
        .alu_src2   (ex_inst.alu_src2),
        .alu_result (alu_result),
        .complete   (alu_complete)
    );

    assign byte_off = alu_result[1:0];

    always_comb begin
        if (ex_inst.size_b) begin
            store_be = 4'b0001 << byte_off;
        end else if (ex_inst.size_h) begin
            store_be = byte_off[1] ? 4'b1100 : 4'b0011;
        end else begin
            store_be = 4'b1111;
        end
    end

    // request only in the cycle the instruction moves into MEM
    assign sram_en    = to_mem_go & (ex_inst.res_from_mem | ex_inst.mem_we);
    assign sram_we    = {4{to_mem_go & ex_inst.mem_we}} & store_be;
    assign sram_addr  = alu_result;
    assign sram_wdata = ex_inst.size_b ? {4{ex_inst.rkd_value[7:0]}}  :
                        ex_inst.size_h ? {2{ex_inst.rkd_value[15:0]}} :
                                         ex_inst.rkd_value;

    assign ex_fwd_bus.res_from_mem = ex_inst.res_from_mem & ex_valid;
    assign ex_fwd_bus.rf_we        = ex_inst.rf_we & ex_valid;
    assign ex_fwd_bus.rf_waddr     = ex_inst.rf_waddr;
    assign ex_fwd_bus.alu_result   = alu_result;

    assign ex_to_mem_bus.pc            = ex_inst.pc;
    assign ex_to_mem_bus.res_from_mem  = ex_inst.res_from_mem & ex_valid;
    assign ex_to_mem_bus.rf_we         = ex_inst.rf_we & ex_valid;
    assign ex_to_mem_bus.rf_waddr      = ex_inst.rf_waddr;
    assign ex_to_mem_bus.alu_result    = alu_result;
    assign ex_to_mem_bus.byte_off      = byte_off;
    assign ex_to_mem_bus.size_b        = ex_inst.size_b;
    assign ex_to_mem_bus.size_h        = ex_inst.size_h;
    assign ex_to_mem_bus.load_unsigned = ex_inst.load_unsigned;

endmodule

`default_nettype wire

/* hw/exmem_config.svh */
`ifndef EXMEM_CONFIG_SVH
`define EXMEM_CONFIG_SVH
`default_nettype none

`define EXMEM_XLEN     32   // data path width
`define EXMEM_SRAM_AW  10   // word address bits of the data ram
`define EXMEM_ALU_OPS  19   // one-hot alu op width

// bit positions inside the one-hot alu op
`define EXMEM_OP_ADD    0
`define EXMEM_OP_SUB    1
`define EXMEM_OP_SLT    2
`define EXMEM_OP_SLTU   3
`define EXMEM_OP_AND    4
`define EXMEM_OP_OR     5
`define EXMEM_OP_NOR    6
`define EXMEM_OP_XOR    7
`define EXMEM_OP_SLL    8
`define EXMEM_OP_SRL    9
`define EXMEM_OP_SRA    10
`define EXMEM_OP_LUI    11
`define EXMEM_OP_MUL    12
`define EXMEM_OP_MULH   13
`define EXMEM_OP_MULHU  14
`define EXMEM_OP_DIV    15
`define EXMEM_OP_DIVU   16
`define EXMEM_OP_MOD    17
`define EXMEM_OP_MODU   18

`default_nettype wire
`endif

/* hw/exmem_pkg.sv */
`include "exmem_config.svh"
`default_nettype none

package exmem_pkg;

    typedef logic [`EXMEM_XLEN-1:0]    word_t;
    typedef logic [4:0]                reg_addr_t;
    typedef logic [`EXMEM_ALU_OPS-1:0] alu_op_t;
    typedef logic [3:0]                byte_en_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

    // decoded instruction handed over by decode
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        word_t     rkd_value;      // store data
        logic      res_from_mem;   // load
        logic      mem_we;         // store
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      size_b;
        logic      size_h;         // neither set means word
        logic      load_unsigned;
    } id_to_ex_t;

    typedef struct packed {
        word_t     pc;
        logic      res_from_mem;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;
        logic [1:0] byte_off;      // low address bits for load alignment
        logic      size_b;
        logic      size_h;
        logic      load_unsigned;
    } ex_to_mem_t;

    typedef struct packed {
        logic      res_from_mem;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;
    } ex_fwd_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } mem_to_wb_t;

endpackage

`default_nettype wire

/* hw/exmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exmem_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_to_ex_valid,
    input  exmem_pkg::id_to_ex_t  id_to_ex_bus,
    input  logic                  wb_allowin,
    input  logic                  ertn_flush,
    output logic                  ex_allowin,
    output exmem_pkg::ex_fwd_t    ex_fwd_bus,
    output logic                  mem_to_wb_valid,
    output exmem_pkg::mem_to_wb_t mem_to_wb_bus
);

    logic                  mem_allowin;
    logic                  ex_to_mem_valid;
    exmem_pkg::ex_to_mem_t ex_to_mem_bus;
    logic                  sram_en;
    exmem_pkg::byte_en_t   sram_we;
    exmem_pkg::word_t      sram_addr;
    exmem_pkg::word_t      sram_wdata;
    exmem_pkg::word_t      sram_rdata;

    ex_stage u_ex (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex_bus    (id_to_ex_bus),
        .mem_allowin     (mem_allowin),
        .ertn_flush      (ertn_flush),
        .ex_allowin      (ex_allowin),
        .ex_fwd_bus      (ex_fwd_bus),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .sram_en         (sram_en),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata)
    );

    mem_stage u_mem (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .sram_rdata      (sram_rdata),
        .wb_allowin      (wb_allowin),
        .mem_allowin     (mem_allowin),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus)
    );

    data_sram u_sram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

`default_nettype wire

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  ex_to_mem_valid,
    input  exmem_pkg::ex_to_mem_t ex_to_mem_bus,
    input  exmem_pkg::word_t      sram_rdata,
    input  logic                  wb_allowin,
    output logic                  mem_allowin,
    output logic                  mem_to_wb_valid,
    output exmem_pkg::mem_to_wb_t mem_to_wb_bus
);

    logic                  mem_valid;
    exmem_pkg::ex_to_mem_t mem_inst;
    exmem_pkg::word_t      rdata_shift;
    exmem_pkg::word_t      load_data;

    assign mem_allowin     = ~mem_valid | wb_allowin;
    assign mem_to_wb_valid = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_inst <= ex_to_mem_bus;
        end
    end

    // bring the addressed byte or halfword down to bit 0
    assign rdata_shift = sram_rdata >> {mem_inst.byte_off, 3'b000};

    always_comb begin
        if (mem_inst.size_b) begin
            load_data = {{24{~mem_inst.load_unsigned & rdata_shift[7]}}, rdata_shift[7:0]};
        end else if (mem_inst.size_h) begin
            load_data = {{16{~mem_inst.load_unsigned & rdata_shift[15]}}, rdata_shift[15:0]};
        end else begin
            load_data = sram_rdata;   // word loads are already aligned
        end
    end

    assign mem_to_wb_bus.pc       = mem_inst.pc;
    assign mem_to_wb_bus.rf_we    = mem_inst.rf_we;
    assign mem_to_wb_bus.rf_waddr = mem_inst.rf_waddr;
    assign mem_to_wb_bus.rf_wdata = mem_inst.res_from_mem ? load_data : mem_inst.alu_result;

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/exmem_pkg.sv
hw/alu.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/data_sram.sv
hw/exmem_top.sv
tb/exmem_properties.sv
tb/exmem_tb.sv

/* tb/exmem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module exmem_properties (
    input logic                  clk,
    input logic                  resetn,
    input logic                  ex_allowin,
    input logic                  sram_en,
    input exmem_pkg::word_t      ex_pc,
    input logic                  mem_to_wb_valid,
    input logic                  wb_allowin,
    input logic                  alu_start,
    input logic                  alu_complete,
    input exmem_pkg::mem_to_wb_t mem_to_wb_bus
);

    // the requesting instruction must show up in MEM on the next cycle
    sram_needs_transfer: assert property (@(posedge clk) disable iff (!resetn)
        sram_en |=> (mem_to_wb_valid && (mem_to_wb_bus.pc == $past(ex_pc))))
        else $error("sram request without the instruction moving into MEM");

    wb_bundle_holds: assert property (@(posedge clk) disable iff (!resetn)
        (mem_to_wb_valid && !wb_allowin) |=> (mem_to_wb_valid && $stable(mem_to_wb_bus)))
        else $error("writeback bundle changed under back-pressure");

    alu_finishes: assert property (@(posedge clk) disable iff (!resetn)
        alu_start |-> ##[1:34] alu_complete)
        else $error("alu complete late");

    allowin_after_reset: assert property (@(posedge clk)
        !resetn |=> ex_allowin)
        else $error("ex_allowin low after reset");

endmodule

bind exmem_top exmem_properties u_props (
    .clk             (clk),
    .resetn          (resetn),
    .ex_allowin      (ex_allowin),
    .sram_en         (sram_en),
    .ex_pc           (ex_to_mem_bus.pc),
    .mem_to_wb_valid (mem_to_wb_valid),
    .wb_allowin      (wb_allowin),
    .alu_start       (u_ex.alu_start),
    .alu_complete    (u_ex.alu_complete),
    .mem_to_wb_bus   (mem_to_wb_bus)
);

`default_nettype wire

/* tb/exmem_tb.sv */
`timescale 1ns/1ps
`include "exmem_config.svh"
`default_nettype none

module exmem_tb;

    typedef struct {
        exmem_pkg::mem_to_wb_t wb;
        int                    due;   // expected cycle of first wb offer or -1
    } exp_entry_t;

    logic                  clk;
    logic                  resetn;
    logic                  id_valid;
    exmem_pkg::id_to_ex_t  id_bus;
    logic                  wb_allowin;
    logic                  ertn_flush;
    logic                  ex_allowin;
    exmem_pkg::ex_fwd_t    ex_fwd_bus;
    logic                  mem_to_wb_valid;
    exmem_pkg::mem_to_wb_t mem_to_wb_bus;

    int         seed = 64;
    int         errors = 0;
    int         checks = 0;
    int         cyc = 0;
    int         stretch = 0;
    bit         bp_on = 0;
    exmem_pkg::word_t pc_next = 32'h1c00_0000;
    exp_entry_t exp_q[$];
    logic [7:0] mem_model [int];   // byte address to byte

    exmem_top DUT (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_valid),
        .id_to_ex_bus    (id_bus),
        .wb_allowin      (wb_allowin),
        .ertn_flush      (ertn_flush),
        .ex_allowin      (ex_allowin),
        .ex_fwd_bus      (ex_fwd_bus),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic end_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("Timeout at %0t: %s never happened", $time, what);
        end_run();
    endtask

    task automatic check_val(input string name, input exmem_pkg::word_t exp,
                             input exmem_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic exmem_pkg::word_t rnd();
        return exmem_pkg::word_t'($random(seed));
    endfunction

    // reference results straight from the operation definitions
    function automatic exmem_pkg::word_t expect_alu(input int op, input exmem_pkg::word_t a,
                                                    input exmem_pkg::word_t b);
        longint          ps;
        longint unsigned pu;
        ps = longint'($signed(a)) * longint'($signed(b));
        pu = {32'b0, a} * {32'b0, b};
        case (op)
            `EXMEM_OP_ADD:   return a + b;
            `EXMEM_OP_SUB:   return a - b;
            `EXMEM_OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `EXMEM_OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            `EXMEM_OP_AND:   return a & b;
            `EXMEM_OP_OR:    return a | b;
            `EXMEM_OP_NOR:   return ~(a | b);
            `EXMEM_OP_XOR:   return a ^ b;
            `EXMEM_OP_SLL:   return a << b[4:0];
            `EXMEM_OP_SRL:   return a >> b[4:0];
            `EXMEM_OP_SRA:   return exmem_pkg::word_t'($signed(a) >>> b[4:0]);
            `EXMEM_OP_LUI:   return b;
            `EXMEM_OP_MUL:   return pu[31:0];
            `EXMEM_OP_MULH:  return ps[63:32];
            `EXMEM_OP_MULHU: return pu[63:32];
            `EXMEM_OP_DIV:   return (b == 0) ? '1 : exmem_pkg::word_t'($signed(a) / $signed(b));
            `EXMEM_OP_DIVU:  return (b == 0) ? '1 : a / b;
            `EXMEM_OP_MOD:   return (b == 0) ? a : exmem_pkg::word_t'($signed(a) % $signed(b));
            default:         return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic exmem_pkg::id_to_ex_t make_inst(input int op, input exmem_pkg::word_t a,
                                                       input exmem_pkg::word_t b);
        exmem_pkg::id_to_ex_t i;
        i          = '0;
        i.pc       = pc_next;
        i.alu_op   = exmem_pkg::alu_op_t'(1) << op;
        i.alu_src1 = a;
        i.alu_src2 = b;
        i.rf_we    = 1'b1;
        i.rf_waddr = exmem_pkg::reg_addr_t'($random(seed));
        return i;
    endfunction

    // decode model offers on the falling edge and waits for allowin
    task automatic issue(input exmem_pkg::id_to_ex_t inst, input exmem_pkg::word_t wdata,
                         input bit push, input bit chk_lat);
        exp_entry_t e;
        int         t;
        @(negedge clk);
        id_valid = 1'b1;
        id_bus   = inst;
        #2;
        t = 0;
        while (!ex_allowin) begin
            @(negedge clk);
            #2;
            t++;
            if (t > 100) timeout_fail("ex_allowin for issue");
        end
        e.wb.pc       = inst.pc;
        e.wb.rf_we    = inst.rf_we;
        e.wb.rf_waddr = inst.rf_waddr;
        e.wb.rf_wdata = wdata;
        e.due         = chk_lat ? cyc + 2 : -1;
        if (push) exp_q.push_back(e);
        pc_next = pc_next + 4;
        @(posedge clk);
    endtask

    task automatic run_alu(input int op, input exmem_pkg::word_t a, input exmem_pkg::word_t b);
        exmem_pkg::id_to_ex_t inst;
        exmem_pkg::word_t     res;
        int                   n;
        inst = make_inst(op, a, b);
        res  = expect_alu(op, a, b);
        issue(inst, res, 1'b1, op < `EXMEM_OP_DIV);
        @(negedge clk);
        id_valid = 1'b0;
        #2;
        if (op < `EXMEM_OP_DIV) begin
            check_val("ex_fwd_bus.rf_we", 32'd1, 32'(ex_fwd_bus.rf_we));
            check_val("ex_fwd_bus.rf_waddr", 32'(inst.rf_waddr), 32'(ex_fwd_bus.rf_waddr));
            check_val("ex_fwd_bus.res_from_mem", 32'd0, 32'(ex_fwd_bus.res_from_mem));
            check_val("ex_fwd_bus.alu_result", res, ex_fwd_bus.alu_result);
        end else begin
            n = 0;
            while (!ex_allowin) begin   // divider holds EX
                n++;
                @(negedge clk);
                #2;
                if (n > 60) timeout_fail("divide completion");
            end
            check_val("div_stall_cycles", 32'd33, 32'(n));
        end
        @(negedge clk);
        #2;
        check_val("ex_fwd_bus.rf_we idle", 32'd0, 32'(ex_fwd_bus.rf_we));
        check_val("ex_fwd_bus.res_from_mem idle", 32'd0, 32'(ex_fwd_bus.res_from_mem));
    endtask

    task automatic store(input exmem_pkg::word_t addr, input exmem_pkg::word_t data,
                         input int size, input bit do_flush);
        exmem_pkg::id_to_ex_t inst;
        inst           = make_inst(`EXMEM_OP_ADD, addr, 32'd0);
        inst.rf_we     = 1'b0;
        inst.rf_waddr  = '0;
        inst.mem_we    = 1'b1;
        inst.rkd_value = data;
        inst.size_b    = (size == 1);
        inst.size_h    = (size == 2);
        issue(inst, addr, !do_flush, 1'b0);
        if (do_flush) begin
            @(negedge clk);
            id_valid   = 1'b0;
            ertn_flush = 1'b1;
            @(negedge clk);
            ertn_flush = 1'b0;
        end else begin
            for (int i = 0; i < size; i++) mem_model[addr + i] = data[8*i +: 8];
        end
    endtask

    task automatic load(input exmem_pkg::word_t addr, input int size, input bit uns);
        exmem_pkg::id_to_ex_t inst;
        exmem_pkg::word_t     v;
        inst               = make_inst(`EXMEM_OP_ADD, addr, 32'd0);
        inst.res_from_mem  = 1'b1;
        inst.size_b        = (size == 1);
        inst.size_h        = (size == 2);
        inst.load_unsigned = uns;
        if (size == 1) begin
            v = {{24{~uns & mem_model[addr][7]}}, mem_model[addr]};
        end else if (size == 2) begin
            v = {{16{~uns & mem_model[addr+1][7]}}, mem_model[addr+1], mem_model[addr]};
        end else begin
            v = {mem_model[addr+3], mem_model[addr+2], mem_model[addr+1], mem_model[addr]};
        end
        issue(inst, v, 1'b1, 1'b0);
        @(negedge clk);
        id_valid = 1'b0;
        #2;
        check_val("ex_fwd_bus.res_from_mem load", 32'd1, 32'(ex_fwd_bus.res_from_mem));
    endtask

    task automatic drain();
        int t;
        t = 0;
        @(negedge clk);
        id_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > 500) timeout_fail("writeback drain");
        end
        repeat (4) @(negedge clk);   // room for a stray writeback
    endtask

    // writeback model with random stall stretches under back-pressure
    initial begin
        wb_allowin = 1'b1;
        forever begin
            @(negedge clk);
            if (!bp_on) begin
                wb_allowin = 1'b1;
            end else if (stretch == 0) begin
                wb_allowin = ~wb_allowin;
                stretch    = 1 + int'($unsigned($random(seed)) % 6);
            end else begin
                stretch--;
            end
        end
    end

    // scoreboard matches accepted writebacks in order
    initial begin
        exp_entry_t e;
        forever begin
            @(negedge clk);
            #2;
            if (resetn && mem_to_wb_valid && wb_allowin) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: writeback for pc %h with nothing expected",
                             $time, mem_to_wb_bus.pc);
                end else begin
                    e = exp_q.pop_front();
                    check_val("mem_to_wb_bus.pc", e.wb.pc, mem_to_wb_bus.pc);
                    check_val("mem_to_wb_bus.rf_we", 32'(e.wb.rf_we), 32'(mem_to_wb_bus.rf_we));
                    check_val("mem_to_wb_bus.rf_waddr", 32'(e.wb.rf_waddr),
                              32'(mem_to_wb_bus.rf_waddr));
                    check_val("mem_to_wb_bus.rf_wdata", e.wb.rf_wdata, mem_to_wb_bus.rf_wdata);
                    if (e.due >= 0) check_val("writeback_cycle", 32'(e.due), 32'(cyc));
                end
            end
        end
    end

    initial begin
        exmem_pkg::word_t a;
        exmem_pkg::word_t b;
        resetn     = 1'b0;
        id_valid   = 1'b0;
        id_bus     = '0;
        ertn_flush = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;

        for (int op = 0; op < `EXMEM_OP_DIV; op++) begin   // single-cycle ops
            for (int k = 0; k < 4; k++) run_alu(op, rnd(), rnd());
        end
        for (int op = `EXMEM_OP_DIV; op <= `EXMEM_OP_MODU; op++) begin
            run_alu(op, 32'd7, 32'd2);
            run_alu(op, -32'sd7, 32'd2);
            run_alu(op, 32'd7, -32'sd2);
            run_alu(op, -32'sd7, -32'sd2);
            run_alu(op, rnd(), 32'd0);
            run_alu(op, rnd(), rnd() | 32'h1);
        end
        drain();

        for (int w = 0; w < 4; w++) store(32'h100 + 4*w, rnd(), 4, 1'b0);
        for (int off = 0; off < 4; off++) begin
            store(32'h100 + off, rnd(), 1, 1'b0);
            load(32'h100 + off, 1, 1'b0);
            load(32'h100 + off, 1, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            store(32'h104 + off, rnd() | 32'h8000, 2, 1'b0);
            load(32'h104 + off, 2, 1'b0);
            load(32'h104 + off, 2, 1'b1);
        end
        load(32'h100, 4, 1'b0);
        load(32'h104, 4, 1'b0);
        drain();

        bp_on = 1'b1;
        for (int k = 0; k < 40; k++) begin
            a = rnd();
            b = rnd();
            if (k % 5 == 4) begin
                load(32'h100 + 4*(k % 2), 4, 1'b0);
            end else begin
                issue(make_inst(k % `EXMEM_OP_DIV, a, b), expect_alu(k % `EXMEM_OP_DIV, a, b),
                      1'b1, 1'b0);
            end
        end
        drain();
        bp_on = 1'b0;

        store(32'h200, 32'h1234_5678, 4, 1'b0);
        issue(make_inst(`EXMEM_OP_DIV, rnd(), 32'd3), 32'd0, 1'b0, 1'b0);
        @(negedge clk);
        id_valid = 1'b0;
        repeat (5) @(negedge clk);
        ertn_flush = 1'b1;   // cancel the divide mid-flight
        @(negedge clk);
        ertn_flush = 1'b0;
        store(32'h200, 32'hdead_beef, 4, 1'b1);
        load(32'h200, 4, 1'b0);
        drain();

        end_run();
    end

endmodule

`default_nettype wire
